// File: video_timing_pkg.sv
/* Raster constants for 640x480 at 60 Hz with a 25 MHz class pixel clock.
   Timing generator, painter and checker reference these by scoped name. */

package video_timing_pkg;

    localparam int CORDW = 10;           // coordinate width, holds 0..1023

    // active picture
    localparam int H_RES = 640;          // visible pixels per line
    localparam int V_RES = 480;          // visible lines per frame

    // horizontal blanking in pixels
    localparam int H_FP   = 16;          // front porch
    localparam int H_SYNC = 96;          // sync pulse
    localparam int H_BP   = 48;          // back porch

    // vertical blanking in lines
    localparam int V_FP   = 10;          // front porch
    localparam int V_SYNC = 2;           // sync pulse
    localparam int V_BP   = 33;          // back porch

    localparam int H_TOTAL = H_RES + H_FP + H_SYNC + H_BP;  // 800
    localparam int V_TOTAL = V_RES + V_FP + V_SYNC + V_BP;  // 525

    // sync windows, start inclusive and end exclusive
    localparam int HS_START = H_RES + H_FP;      // 656
    localparam int HS_END   = HS_START + H_SYNC; // 752
    localparam int VS_START = V_RES + V_FP;      // 490
    localparam int VS_END   = VS_START + V_SYNC; // 492

    localparam logic SYNC_ACTIVE = 1'b0; // negative polarity for this mode

endpackage

// File: scene_pkg.sv
/* Scene description for the bouncing squares.
   Sizes, speeds and start positions are indexed by square number. */

package scene_pkg;

    localparam int NUM_SQUARES = 3;      // red, green, blue
    localparam int COLRW = 4;            // bits per colour channel

    // edge length in pixels
    localparam int SQ_SIZE [NUM_SQUARES] = '{100, 150, 200};

    // pixels moved per frame on each axis
    localparam int SQ_SPEED [NUM_SQUARES] = '{3, 2, 2};

    // start positions sit a few steps short of the right and bottom edges
    // so every square bounces on both axes within the first frames
    //   sq0  edge x 537, edge y 377
    //   sq1  edge x 488, edge y 328
    //   sq2  edge x 438, edge y 278
    localparam int SQ_START_X [NUM_SQUARES] = '{530, 482, 432};
    localparam int SQ_START_Y [NUM_SQUARES] = '{370, 322, 272};

    // channel intensities
    localparam logic [COLRW-1:0] COL_ON  = {COLRW{1'b1}};  // full
    localparam logic [COLRW-1:0] COL_OFF = {COLRW{1'b0}};  // dark

    // square 0 paints red, 1 green, 2 blue
    localparam int CH_RED   = 0;
    localparam int CH_GREEN = 1;
    localparam int CH_BLUE  = 2;

endpackage

// File: display_timings.sv
/* Raster timing generator. Walks the full 800x525 frame and flags sync,
   data enable and a one-cycle strobe at the first blanking line. */

`timescale 1ns/100ps

module display_timings (
    input  logic                                clk_pix,
    input  logic                                rst,
    output logic [video_timing_pkg::CORDW-1:0]  sx,     // pixel column
    output logic [video_timing_pkg::CORDW-1:0]  sy,     // pixel row
    output logic                                hsync,
    output logic                                vsync,
    output logic                                de,     // visible area
    output logic                                frame   // start of vblank
);

    localparam int CW = video_timing_pkg::CORDW;

    localparam logic [CW-1:0] H_LAST   = CW'(video_timing_pkg::H_TOTAL - 1);
    localparam logic [CW-1:0] V_LAST   = CW'(video_timing_pkg::V_TOTAL - 1);
    localparam logic [CW-1:0] H_ACT    = CW'(video_timing_pkg::H_RES);
    localparam logic [CW-1:0] V_ACT    = CW'(video_timing_pkg::V_RES);
    localparam logic [CW-1:0] HS_FIRST = CW'(video_timing_pkg::HS_START);
    localparam logic [CW-1:0] HS_STOP  = CW'(video_timing_pkg::HS_END);
    localparam logic [CW-1:0] VS_FIRST = CW'(video_timing_pkg::VS_START);
    localparam logic [CW-1:0] VS_STOP  = CW'(video_timing_pkg::VS_END);

    logic h_wrap;                        // last pixel of a line
    logic v_wrap;                        // last line of a frame

    assign h_wrap = (sx == H_LAST);
    assign v_wrap = (sy == V_LAST);

    // raster counters
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx <= '0;
            sy <= '0;
        end else if (h_wrap) begin
            sx <= '0;                    // new line
            sy <= v_wrap ? '0 : sy + 1'b1;
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // sync windows from the package, polarity from SYNC_ACTIVE
    always_comb begin
        hsync = (sx >= HS_FIRST && sx < HS_STOP) ? video_timing_pkg::SYNC_ACTIVE
                                                 : ~video_timing_pkg::SYNC_ACTIVE;
        vsync = (sy >= VS_FIRST && sy < VS_STOP) ? video_timing_pkg::SYNC_ACTIVE
                                                 : ~video_timing_pkg::SYNC_ACTIVE;
    end

    assign de = (sx < H_ACT) && (sy < V_ACT);

    // one pulse per frame, first pixel slot of line 480
    assign frame = (sy == V_ACT) && (sx == '0);

endmodule

// File: square_mover.sv
/* Position and direction state for one square. IDX picks its size, speed
   and start point from the scene package; it steps once per frame strobe. */

`timescale 1ns/100ps

module square_mover #(
    parameter int IDX = 0                // square number, below NUM_SQUARES
) (
    input  logic                                clk_pix,
    input  logic                                rst,
    input  logic                                frame,  // start of vblank
    output logic [video_timing_pkg::CORDW-1:0]  qx,     // left edge
    output logic [video_timing_pkg::CORDW-1:0]  qy      // top edge
);

    localparam int CW = video_timing_pkg::CORDW;

    localparam int SIZE  = scene_pkg::SQ_SIZE[IDX];
    localparam int SPEED = scene_pkg::SQ_SPEED[IDX];

    localparam logic [CW-1:0] STEP    = CW'(SPEED);
    localparam logic [CW-1:0] START_X = CW'(scene_pkg::SQ_START_X[IDX]);
    localparam logic [CW-1:0] START_Y = CW'(scene_pkg::SQ_START_Y[IDX]);

    // far edge thresholds, next step would cross the border
    localparam logic [CW-1:0] EDGE_X = CW'(video_timing_pkg::H_RES - (SIZE + SPEED));
    localparam logic [CW-1:0] EDGE_Y = CW'(video_timing_pkg::V_RES - (SIZE + SPEED));

    logic dx;                            // 1 means moving left
    logic dy;                            // 1 means moving up

    logic [CW:0] next_x;                 // {dir, pos} after one step
    logic [CW:0] next_y;

    // one axis of the reflecting step
    // far edge wins over near edge so a square never leaves the screen
    function automatic logic [CW:0] step_axis(
        input logic [CW-1:0] pos,
        input logic          dir,
        input logic [CW-1:0] far_edge
    );
        logic          new_dir;
        logic [CW-1:0] new_pos;
        if (pos >= far_edge) begin
            new_dir = 1'b1;              // bounce back
            new_pos = pos - STEP;
        end else if (pos < STEP) begin
            new_dir = 1'b0;              // bounce off origin side
            new_pos = pos + STEP;
        end else begin
            new_dir = dir;               // keep going
            new_pos = dir ? pos - STEP : pos + STEP;
        end
        return {new_dir, new_pos};
    endfunction

    assign next_x = step_axis(qx, dx, EDGE_X);
    assign next_y = step_axis(qy, dy, EDGE_Y);

    // scene state, held for a whole frame
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            qx <= START_X;
            qy <= START_Y;
            dx <= 1'b0;                  // right
            dy <= 1'b0;                  // down
        end else if (frame) begin
            {dx, qx} <= next_x;
            {dy, qy} <= next_y;
        end
    end

endmodule

// File: square_painter.sv
/* Colours the current pixel from three square positions and registers
   sync, enable and colour together, standing in for the board output pins. */

`timescale 1ns/100ps

module square_painter (
    input  logic                                clk_pix,
    input  logic                                rst,
    input  logic [video_timing_pkg::CORDW-1:0]  sx,
    input  logic [video_timing_pkg::CORDW-1:0]  sy,
    input  logic                                hsync,
    input  logic                                vsync,
    input  logic                                de,
    input  logic [video_timing_pkg::CORDW-1:0]  q0x,
    input  logic [video_timing_pkg::CORDW-1:0]  q0y,
    input  logic [video_timing_pkg::CORDW-1:0]  q1x,
    input  logic [video_timing_pkg::CORDW-1:0]  q1y,
    input  logic [video_timing_pkg::CORDW-1:0]  q2x,
    input  logic [video_timing_pkg::CORDW-1:0]  q2y,
    output logic                                vid_hsync,
    output logic                                vid_vsync,
    output logic                                vid_de,
    output logic [scene_pkg::COLRW-1:0]         vid_r,
    output logic [scene_pkg::COLRW-1:0]         vid_g,
    output logic [scene_pkg::COLRW-1:0]         vid_b
);

    localparam int CW = video_timing_pkg::CORDW;

    logic draw [scene_pkg::NUM_SQUARES];  // pixel inside square n

    // rectangle test, one extra bit so the far edge cannot wrap
    function automatic logic in_square(
        input logic [CW-1:0] x0,
        input logic [CW-1:0] y0,
        input int            size
    );
        logic [CW:0] x_end;
        logic [CW:0] y_end;
        x_end = {1'b0, x0} + (CW+1)'(size);
        y_end = {1'b0, y0} + (CW+1)'(size);
        return (sx >= x0) && ({1'b0, sx} < x_end)
            && (sy >= y0) && ({1'b0, sy} < y_end);
    endfunction

    always_comb begin
        draw[0] = in_square(q0x, q0y, scene_pkg::SQ_SIZE[0]);
        draw[1] = in_square(q1x, q1y, scene_pkg::SQ_SIZE[1]);
        draw[2] = in_square(q2x, q2y, scene_pkg::SQ_SIZE[2]);
    end

    // output register, reset drives blank video with idle syncs
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            vid_hsync <= ~video_timing_pkg::SYNC_ACTIVE;
            vid_vsync <= ~video_timing_pkg::SYNC_ACTIVE;
            vid_de    <= 1'b0;
            vid_r     <= scene_pkg::COL_OFF;
            vid_g     <= scene_pkg::COL_OFF;
            vid_b     <= scene_pkg::COL_OFF;
        end else begin
            vid_hsync <= hsync;
            vid_vsync <= vsync;
            vid_de    <= de;
            vid_r <= (de && draw[scene_pkg::CH_RED])   ? scene_pkg::COL_ON : scene_pkg::COL_OFF;
            vid_g <= (de && draw[scene_pkg::CH_GREEN]) ? scene_pkg::COL_ON : scene_pkg::COL_OFF;
            vid_b <= (de && draw[scene_pkg::CH_BLUE])  ? scene_pkg::COL_ON : scene_pkg::COL_OFF;
        end
    end

endmodule

// File: bounce_top.sv
/* Bouncing squares video source. Timing generator feeds three movers and
   the painter; video leaves one cycle after the raster counters. */

`timescale 1ns/100ps

module bounce_top (
    input  logic                         clk_pix,
    input  logic                         rst,
    output logic                         vid_hsync,
    output logic                         vid_vsync,
    output logic                         vid_de,
    output logic [scene_pkg::COLRW-1:0]  vid_r,
    output logic [scene_pkg::COLRW-1:0]  vid_g,
    output logic [scene_pkg::COLRW-1:0]  vid_b
);

    logic [video_timing_pkg::CORDW-1:0] sx;       // raster position
    logic [video_timing_pkg::CORDW-1:0] sy;
    logic                               hsync;
    logic                               vsync;
    logic                               de;
    logic                               frame;    // vblank strobe

    logic [video_timing_pkg::CORDW-1:0] q0x, q0y; // square positions
    logic [video_timing_pkg::CORDW-1:0] q1x, q1y;
    logic [video_timing_pkg::CORDW-1:0] q2x, q2y;

    display_timings timings (
        .clk_pix (clk_pix),
        .rst     (rst),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .frame   (frame)
    );

    // positions only change in blanking
    square_mover #(.IDX(0)) mover0 (.clk_pix(clk_pix), .rst(rst), .frame(frame), .qx(q0x), .qy(q0y));
    square_mover #(.IDX(1)) mover1 (.clk_pix(clk_pix), .rst(rst), .frame(frame), .qx(q1x), .qy(q1y));
    square_mover #(.IDX(2)) mover2 (.clk_pix(clk_pix), .rst(rst), .frame(frame), .qx(q2x), .qy(q2y));

    square_painter painter (
        .clk_pix   (clk_pix),
        .rst       (rst),
        .sx        (sx),
        .sy        (sy),
        .hsync     (hsync),
        .vsync     (vsync),
        .de        (de),
        .q0x       (q0x),
        .q0y       (q0y),
        .q1x       (q1x),
        .q1y       (q1y),
        .q2x       (q2x),
        .q2y       (q2y),
        .vid_hsync (vid_hsync),
        .vid_vsync (vid_vsync),
        .vid_de    (vid_de),
        .vid_r     (vid_r),
        .vid_g     (vid_g),
        .vid_b     (vid_b)
    );

endmodule

// File: bounce_checker.sv
/* Watches the DUT video ports, rebuilds the raster from vid_de, models the
   three squares and compares every cycle. Prints one line per finished test. */

`timescale 1ns/100ps

module bounce_checker (
    input  logic                         clk_pix,
    input  logic                         rst,
    input  logic                         vid_hsync,
    input  logic                         vid_vsync,
    input  logic                         vid_de,
    input  logic [scene_pkg::COLRW-1:0]  vid_r,
    input  logic [scene_pkg::COLRW-1:0]  vid_g,
    input  logic [scene_pkg::COLRW-1:0]  vid_b,
    output int                           frames_done,
    output int                           pass_count,
    output int                           fail_count
);

    localparam int NSQ = scene_pkg::NUM_SQUARES;
    localparam int CRW = scene_pkg::COLRW;

    int qx [NSQ];                        // model positions
    int qy [NSQ];
    bit dx [NSQ];                        // 1 = left
    bit dy [NSQ];                        // 1 = up
    int x_flips [NSQ];
    int y_flips [NSQ];

    int px, py;                          // rebuilt raster position
    int line_len, de_len, hs_len, vs_len;
    bit de_q, hs_q, vs_q, line_seen;
    bit rst_q = 1'b0;
    bit in_reset = 1'b0;
    bit after_reset = 1'b0;
    int errs = 0;
    int last_errs = 0;                   // errors of the frame just closed
    int printed = 0;                     // cap on error lines

    initial begin
        frames_done = 0;
        pass_count = 0;
        fail_count = 0;
    end

    always @(posedge clk_pix) rst_q <= rst;  // outputs follow rst one edge later

    // reference picture: square n lights channel n
    function automatic logic [3*CRW-1:0] expected_colour(input int x, input int y);
        logic [CRW-1:0] ch [NSQ];
        for (int n = 0; n < NSQ; n++) begin
            ch[n] = (x >= qx[n] && x < qx[n] + scene_pkg::SQ_SIZE[n] &&
                     y >= qy[n] && y < qy[n] + scene_pkg::SQ_SIZE[n]) ? scene_pkg::COL_ON
                                                                      : scene_pkg::COL_OFF;
        end
        return {ch[0], ch[1], ch[2]};
    endfunction

    task automatic check_val(input string name, input int exp, input int act);
        if (exp != act) begin
            errs++;
            if (printed < 20) begin
                $display("error at %0d ns: %s expected %0d got %0d", $time, name, exp, act);
            end
            printed++;
        end
    endtask

    task automatic finish_test(input string what);
        if (errs == 0) begin
            pass_count++;
            $display("test %s: pass", what);
        end else begin
            fail_count++;
            $display("test %s: fail with %0d errors", what, errs);
        end
        errs = 0;
    endtask

    // one axis of the bounce rule
    task automatic step_axis(inout int pos, inout bit dir, inout int flips,
                             input int size, input int speed, input int res);
        bit old_dir;
        old_dir = dir;
        if (pos >= res - (size + speed)) dir = 1'b1;
        else if (pos < speed) dir = 1'b0;
        pos = dir ? pos - speed : pos + speed;
        if (dir != old_dir) flips++;
    endtask

    task automatic reset_model();
        for (int n = 0; n < NSQ; n++) begin
            qx[n] = scene_pkg::SQ_START_X[n];
            qy[n] = scene_pkg::SQ_START_Y[n];
            dx[n] = 1'b0;
            dy[n] = 1'b0;
        end
        px = 0;
        py = 0;
        line_len = 0;
        de_len = 0;
        hs_len = 0;
        vs_len = 0;
        de_q = 0;
        hs_q = 0;
        vs_q = 0;
        line_seen = 0;
    endtask

    // compare process, samples mid-cycle where outputs are stable
    always @(negedge clk_pix) begin
        logic [3*CRW-1:0] exp;
        bit hs_act;
        bit vs_act;
        hs_act = (vid_hsync == video_timing_pkg::SYNC_ACTIVE);
        vs_act = (vid_vsync == video_timing_pkg::SYNC_ACTIVE);
        if (rst_q) begin
            if (!in_reset && errs != 0) finish_test("frame cut by reset");
            if (!in_reset) errs = 0;
            in_reset = 1'b1;
            check_val("vid_de", 0, vid_de);
            check_val("vid_r", 0, vid_r);
            check_val("vid_g", 0, vid_g);
            check_val("vid_b", 0, vid_b);
            check_val("vid_hsync", 1, vid_hsync);
            check_val("vid_vsync", 1, vid_vsync);
            reset_model();
        end else begin
            if (in_reset) begin
                finish_test("reset levels");
                in_reset = 1'b0;
                after_reset = (frames_done > 0);
            end
            line_len++;
            if (vid_de && !de_q) begin   // line start
                if (line_seen) check_val("line length", video_timing_pkg::H_TOTAL, line_len);
                line_seen = 1'b1;
                line_len = 0;
                de_len = 0;
                px = 0;
            end
            if (vid_de) begin
                exp = expected_colour(px, py);
                check_val("vid_r", exp[3*CRW-1:2*CRW], vid_r);
                check_val("vid_g", exp[2*CRW-1:CRW], vid_g);
                check_val("vid_b", exp[CRW-1:0], vid_b);
                if (hs_act || vs_act) check_val("vid_de during sync", 0, 1);
                px++;
                de_len++;
            end else begin
                check_val("vid_r blank", 0, vid_r);
                check_val("vid_g blank", 0, vid_g);
                check_val("vid_b blank", 0, vid_b);
            end
            if (!vid_de && de_q) begin   // line end
                check_val("enabled pixels", video_timing_pkg::H_RES, de_len);
                py++;
            end
            if (hs_act) hs_len++;
            if (!hs_act && hs_q) begin
                check_val("hsync pulse", video_timing_pkg::H_SYNC, hs_len);
                hs_len = 0;
            end
            if (vs_act) vs_len++;
            if (!vs_act && vs_q) begin
                check_val("vsync cycles", video_timing_pkg::V_SYNC * video_timing_pkg::H_TOTAL,
                          vs_len);
                vs_len = 0;
            end
            if (vs_act && !vs_q) begin   // frame done, step model in blanking
                check_val("enabled lines", video_timing_pkg::V_RES, py);
                last_errs = errs;
                finish_test($sformatf("frame %0d%s", frames_done,
                                      after_reset ? " after reset" : ""));
                for (int n = 0; n < NSQ; n++) begin
                    step_axis(qx[n], dx[n], x_flips[n], scene_pkg::SQ_SIZE[n],
                              scene_pkg::SQ_SPEED[n], video_timing_pkg::H_RES);
                    step_axis(qy[n], dy[n], y_flips[n], scene_pkg::SQ_SIZE[n],
                              scene_pkg::SQ_SPEED[n], video_timing_pkg::V_RES);
                end
                frames_done++;
                py = 0;
                line_seen = 1'b0;        // vblank is not a line
                if (frames_done == 5) begin  // frame 4 shows every bounce
                    for (int n = 0; n < NSQ; n++) begin
                        if (x_flips[n] == 0 || y_flips[n] == 0) begin
                            errs++;
                            $display("square %0d did not change direction on both axes", n);
                        end
                    end
                    if (last_errs != 0) begin
                        errs++;
                        $display("picture after the bounce does not match the model");
                    end
                    finish_test("reflection on both axes");
                end
            end
            de_q = vid_de;
            hs_q = hs_act;
            vs_q = vs_act;
        end
    end

endmodule

// File: bounce_asserts.sv
/* Protocol assertions on the registered video outputs.
   Bound into bounce_top from the testbench top. */

`timescale 1ns/100ps

module bounce_asserts (
    input logic                         clk_pix,
    input logic                         rst,
    input logic                         vid_hsync,
    input logic                         vid_vsync,
    input logic                         vid_de,
    input logic [scene_pkg::COLRW-1:0]  vid_r,
    input logic [scene_pkg::COLRW-1:0]  vid_g,
    input logic [scene_pkg::COLRW-1:0]  vid_b
);

    logic hs_act;
    logic vs_act;
    int   hs_len;                        // length of the running hsync pulse

    assign hs_act = (vid_hsync == video_timing_pkg::SYNC_ACTIVE);
    assign vs_act = (vid_vsync == video_timing_pkg::SYNC_ACTIVE);

    always_ff @(posedge clk_pix) begin
        if (rst) hs_len <= 0;
        else     hs_len <= hs_act ? hs_len + 1 : 0;
    end

    de_outside_sync: assert property (@(posedge clk_pix) disable iff (rst)
        vid_de |-> (!hs_act && !vs_act)) else $error("vid_de high while a sync is active");

    dark_when_blank: assert property (@(posedge clk_pix) disable iff (rst)
        !vid_de |-> (vid_r == '0 && vid_g == '0 && vid_b == '0))
        else $error("colour on while vid_de is low");

    hsync_width: assert property (@(posedge clk_pix) disable iff (rst)
        $fell(hs_act) |-> (hs_len == video_timing_pkg::H_SYNC))
        else $error("hsync pulse length differs from H_SYNC");

endmodule

// File: tb_bounce.sv
/* Testbench top for the bouncing squares generator. Drives clock and reset,
   pulses a mid-run reset at an LCG-chosen cycle and prints the summary. */

`timescale 1ns/100ps

module tb_bounce;

    localparam int FRAME_CYCLES = video_timing_pkg::H_TOTAL * video_timing_pkg::V_TOTAL;
    localparam int RUN_FRAMES   = 7;             // budget for the whole run
    localparam int MARGIN       = 20000;         // reset pulses and pipeline slack
    localparam int LIMIT        = RUN_FRAMES * FRAME_CYCLES + MARGIN;
    localparam logic [31:0] SEED = 32'h3080_d88e;
    localparam int PRE_RESET_FRAMES = 5;         // frames 0..4, reflections in 4
    localparam int TOTAL_FRAMES     = 7;         // plus two frames after reset
    localparam int RESET_WINDOW = 75 * video_timing_pkg::H_TOTAL;  // rest of vblank, top of frame 5

    logic                         clk_pix = 1'b0;
    logic                         rst = 1'b1;
    logic                         vid_hsync;
    logic                         vid_vsync;
    logic                         vid_de;
    logic [scene_pkg::COLRW-1:0]  vid_r;
    logic [scene_pkg::COLRW-1:0]  vid_g;
    logic [scene_pkg::COLRW-1:0]  vid_b;

    int          frames_done;                    // from the checker
    int          pass_count;
    int          fail_count;

    int          cycles = 0;                     // timeout counter
    int          offset;
    logic [31:0] rnd;

    always #4 clk_pix = ~clk_pix;                // 8 ns period

    bounce_top dut (
        .clk_pix   (clk_pix),
        .rst       (rst),
        .vid_hsync (vid_hsync),
        .vid_vsync (vid_vsync),
        .vid_de    (vid_de),
        .vid_r     (vid_r),
        .vid_g     (vid_g),
        .vid_b     (vid_b)
    );

    bounce_checker chk (.*);

    bind bounce_top bounce_asserts asserts (.*);

    // linear congruential step
    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("timeout: run exceeded %0d cycles before all frames were checked", LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        repeat (5) @(posedge clk_pix);
        #1 rst = 1'b0;
        while (frames_done < PRE_RESET_FRAMES) @(posedge clk_pix);
        rnd = lcg_next(SEED);
        offset = int'(rnd % RESET_WINDOW);       // late frame 4 blanking or early frame 5
        repeat (offset) @(posedge clk_pix);
        #1 rst = 1'b1;
        repeat (5) @(posedge clk_pix);
        #1 rst = 1'b0;
        while (frames_done < TOTAL_FRAMES) @(posedge clk_pix);
        repeat (2) @(posedge clk_pix);
        $display("summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
        if (fail_count == 0 && pass_count > 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: bounce.f
video_timing_pkg.sv
scene_pkg.sv
display_timings.sv
square_mover.sv
square_painter.sv
bounce_top.sv
bounce_checker.sv
bounce_asserts.sv
tb_bounce.sv

// File: Makefile
# Verilator build and run for the bouncing squares testbench

VERILATOR ?= verilator
TOP       ?= tb_bounce
LOG       ?= sim.log
FILELIST  ?= bounce.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "ALL TESTS PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
